//--- id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

`define WORD_W       32
`define REG_ADDR_W   5
`define ALUOP_W      8
`define ALUSEL_W     3
`define NOP_REG_ADDR 5'b00000

// major opcodes
`define OP_SPECIAL   6'b000000
`define OP_ORI       6'b001101
`define OP_ANDI      6'b001100
`define OP_XORI      6'b001110
`define OP_LUI       6'b001111
`define OP_ADDI      6'b001000
`define OP_ADDIU     6'b001001
`define OP_SLTI      6'b001010
`define OP_SLTIU     6'b001011

// function field of SPECIAL
`define FN_OR        6'b100101
`define FN_AND       6'b100100
`define FN_XOR       6'b100110
`define FN_NOR       6'b100111
`define FN_SLL       6'b000000
`define FN_SRL       6'b000010
`define FN_SRA       6'b000011
`define FN_SLLV      6'b000100
`define FN_SRLV      6'b000110
`define FN_SRAV      6'b000111
`define FN_ADD       6'b100000
`define FN_ADDU      6'b100001
`define FN_SUB       6'b100010
`define FN_SUBU      6'b100011
`define FN_SLT       6'b101010
`define FN_SLTU      6'b101011

// ALU operation codes
`define ALUOP_NOP    8'b00000000
`define ALUOP_OR     8'b00100101
`define ALUOP_AND    8'b00100100
`define ALUOP_XOR    8'b00100110
`define ALUOP_NOR    8'b00100111
`define ALUOP_SLL    8'b01111100
`define ALUOP_SRL    8'b00000010
`define ALUOP_SRA    8'b00000011
`define ALUOP_ADD    8'b00100000
`define ALUOP_ADDU   8'b00100001
`define ALUOP_SUB    8'b00100010
`define ALUOP_SUBU   8'b00100011
`define ALUOP_SLT    8'b00101010
`define ALUOP_SLTU   8'b00101011
`define ALUOP_ADDI   8'b01010101
`define ALUOP_ADDIU  8'b01010110

// result classes
`define RES_NOP      3'b000
`define RES_LOGIC    3'b001
`define RES_SHIFT    3'b010
`define RES_ARITH    3'b100

`endif

//--- mips_isa_pkg.sv
`default_nettype none
`include "id_macros.svh"

package mips_isa_pkg;

   typedef logic [`WORD_W-1:0]     word_t;
   typedef logic [`WORD_W-1:0]     inst_t;
   typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

   // instruction fields
   typedef logic [5:0]             opcode_t;
   typedef logic [5:0]             funct_t;
   typedef logic [4:0]             shamt_t;
   typedef logic [15:0]            imm16_t;

endpackage

`default_nettype wire

//--- id_ctrl_pkg.sv
`default_nettype none
`include "id_macros.svh"

package id_ctrl_pkg;

   typedef logic [`ALUOP_W-1:0]  aluop_t;   // operation within a class
   typedef logic [`ALUSEL_W-1:0] alusel_t;  // result class for execute

endpackage

`default_nettype wire

//--- id_dec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface id_dec_if import mips_isa_pkg::*, id_ctrl_pkg::*; ();

   aluop_t    aluop;
   alusel_t   alusel;
   reg_addr_t wd;          // destination register
   logic      wreg;
   logic      instvalid;
   logic      reg1_read;
   logic      reg2_read;
   reg_addr_t reg1_addr;
   reg_addr_t reg2_addr;
   word_t     imm;         // already extended

   modport dec (
      output aluop, alusel, wd, wreg, instvalid,
      output reg1_read, reg2_read, reg1_addr, reg2_addr, imm
   );

   modport opnd (
      input reg1_read, reg2_read, reg1_addr, reg2_addr, imm
   );

   modport pipe (
      input aluop, alusel, wd, wreg, instvalid
   );

endinterface

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_macros.svh"

module inst_decoder import mips_isa_pkg::*, id_ctrl_pkg::*; (
   input  inst_t inst_i,
   id_dec_if.dec dec
);

   opcode_t   opcode;
   reg_addr_t rs;
   reg_addr_t rt;
   reg_addr_t rd;
   shamt_t    shamt;
   funct_t    funct;
   imm16_t    imm16;

   aluop_t    fn_aluop;    // from funct
   alusel_t   fn_sel;
   aluop_t    op_aluop;    // from opcode, immediate forms
   alusel_t   op_sel;
   word_t     op_imm;
   word_t     sext_imm;
   logic      shift_imm;   // SLL/SRL/SRA

   assign opcode    = inst_i[31:26];
   assign rs        = inst_i[25:21];
   assign rt        = inst_i[20:16];
   assign rd        = inst_i[15:11];
   assign shamt     = inst_i[10:6];
   assign funct     = inst_i[5:0];
   assign imm16     = inst_i[15:0];
   assign sext_imm  = {{16{imm16[15]}}, imm16};
   assign shift_imm = (funct == `FN_SLL) || (funct == `FN_SRL) || (funct == `FN_SRA);

   always_comb begin
      case (funct)
         `FN_OR:            fn_aluop = `ALUOP_OR;
         `FN_AND:           fn_aluop = `ALUOP_AND;
         `FN_XOR:           fn_aluop = `ALUOP_XOR;
         `FN_NOR:           fn_aluop = `ALUOP_NOR;
         `FN_SLL, `FN_SLLV: fn_aluop = `ALUOP_SLL;
         `FN_SRL, `FN_SRLV: fn_aluop = `ALUOP_SRL;
         `FN_SRA, `FN_SRAV: fn_aluop = `ALUOP_SRA;
         `FN_ADD:           fn_aluop = `ALUOP_ADD;
         `FN_ADDU:          fn_aluop = `ALUOP_ADDU;
         `FN_SUB:           fn_aluop = `ALUOP_SUB;
         `FN_SUBU:          fn_aluop = `ALUOP_SUBU;
         `FN_SLT:           fn_aluop = `ALUOP_SLT;
         `FN_SLTU:          fn_aluop = `ALUOP_SLTU;
         default:           fn_aluop = `ALUOP_NOP;
      endcase
      case (funct)
         `FN_OR, `FN_AND, `FN_XOR, `FN_NOR:
            fn_sel = `RES_LOGIC;
         `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV:
            fn_sel = `RES_SHIFT;
         `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU:
            fn_sel = `RES_ARITH;
         default:
            fn_sel = `RES_NOP;   // unknown funct
      endcase
   end

   always_comb begin
      op_aluop = `ALUOP_NOP;
      op_sel   = `RES_NOP;
      op_imm   = sext_imm;
      case (opcode)
         `OP_ORI, `OP_ANDI, `OP_XORI: begin
            op_sel = `RES_LOGIC;
            op_imm = {16'h0, imm16};   // logic ops zero-extend
            if (opcode == `OP_ORI)
               op_aluop = `ALUOP_OR;
            else if (opcode == `OP_ANDI)
               op_aluop = `ALUOP_AND;
            else
               op_aluop = `ALUOP_XOR;
         end
         `OP_LUI: begin
            op_aluop = `ALUOP_OR;   // or with $rs into upper half
            op_sel   = `RES_LOGIC;
            op_imm   = {imm16, 16'h0};
         end
         `OP_ADDI: begin
            op_aluop = `ALUOP_ADDI;
            op_sel   = `RES_ARITH;
         end
         `OP_ADDIU: begin
            op_aluop = `ALUOP_ADDIU;
            op_sel   = `RES_ARITH;
         end
         `OP_SLTI: begin
            op_aluop = `ALUOP_SLT;
            op_sel   = `RES_ARITH;
         end
         `OP_SLTIU: begin
            op_aluop = `ALUOP_SLTU;
            op_sel   = `RES_ARITH;
         end
         default: begin
            op_sel = `RES_NOP;
         end
      endcase
   end

   always_comb begin
      dec.aluop     = `ALUOP_NOP;
      dec.alusel    = `RES_NOP;
      dec.wd        = rd;
      dec.wreg      = 1'b0;
      dec.instvalid = 1'b0;
      dec.reg1_read = 1'b0;
      dec.reg2_read = 1'b0;
      dec.imm       = '0;
      if (opcode == `OP_SPECIAL) begin
         if (shift_imm && rs == `NOP_REG_ADDR) begin   // bits 31..21 clear
            dec.aluop     = fn_aluop;
            dec.alusel    = fn_sel;
            dec.wreg      = 1'b1;
            dec.instvalid = 1'b1;
            dec.reg2_read = 1'b1;
            dec.imm       = word_t'(shamt);
         end else if (!shift_imm && shamt == 5'd0 && fn_sel != `RES_NOP) begin
            dec.aluop     = fn_aluop;
            dec.alusel    = fn_sel;
            dec.wreg      = 1'b1;
            dec.instvalid = 1'b1;
            dec.reg1_read = 1'b1;
            dec.reg2_read = 1'b1;
         end
      end else if (op_sel != `RES_NOP) begin
         dec.aluop     = op_aluop;
         dec.alusel    = op_sel;
         dec.wd        = rt;   // immediate forms write rt
         dec.wreg      = 1'b1;
         dec.instvalid = 1'b1;
         dec.reg1_read = 1'b1;
         dec.imm       = op_imm;
      end
   end

   assign dec.reg1_addr = rs;
   assign dec.reg2_addr = rt;

endmodule

`default_nettype wire

//--- operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import mips_isa_pkg::*; (
   id_dec_if.opnd    opnd,
   input  logic      sel_i,        // 0 first operand, 1 second
   input  word_t     rf_data_i,
   input  logic      ex_wreg_i,
   input  reg_addr_t ex_wd_i,
   input  word_t     ex_wdata_i,
   input  logic      mem_wreg_i,
   input  reg_addr_t mem_wd_i,
   input  word_t     mem_wdata_i,
   output word_t     operand_o
);

   logic      rd_en;
   reg_addr_t rd_addr;

   assign rd_en   = sel_i ? opnd.reg2_read : opnd.reg1_read;
   assign rd_addr = sel_i ? opnd.reg2_addr : opnd.reg1_addr;

   always_comb begin
      if (!rd_en)
         operand_o = opnd.imm;
      else if (ex_wreg_i && ex_wd_i == rd_addr)
         operand_o = ex_wdata_i;    // youngest result wins
      else if (mem_wreg_i && mem_wd_i == rd_addr)
         operand_o = mem_wdata_i;
      else
         operand_o = rf_data_i;
   end

endmodule

`default_nettype wire

//--- id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_macros.svh"

module id_ex_reg import mips_isa_pkg::*, id_ctrl_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   id_dec_if.pipe    pipe,
   input  word_t     reg1_i,
   input  word_t     reg2_i,
   output aluop_t    ex_aluop_o,
   output alusel_t   ex_alusel_o,
   output word_t     ex_reg1_o,
   output word_t     ex_reg2_o,
   output reg_addr_t ex_wd_o,
   output logic      ex_wreg_o,
   output logic      ex_invalid_o
);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ex_aluop_o   <= `ALUOP_NOP;
         ex_alusel_o  <= `RES_NOP;
         ex_reg1_o    <= '0;
         ex_reg2_o    <= '0;
         ex_wd_o      <= `NOP_REG_ADDR;
         ex_wreg_o    <= 1'b0;
         ex_invalid_o <= 1'b0;
      end else begin
         ex_aluop_o   <= pipe.aluop;
         ex_alusel_o  <= pipe.alusel;
         ex_reg1_o    <= reg1_i;
         ex_reg2_o    <= reg2_i;
         ex_wd_o      <= pipe.wd;
         ex_wreg_o    <= pipe.wreg;
         ex_invalid_o <= !pipe.instvalid;
      end
   end

   // no write leaves the stage straight out of reset
   a_reset_wreg : assert property (
      @(posedge clk_i) !rst_n_i |=> !ex_wreg_o
   );

   // an undecodable word reaches execute as a harmless bubble
   a_invalid_bubble : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      ex_invalid_o |-> (!ex_wreg_o && ex_aluop_o == `ALUOP_NOP)
   );

   a_nop_no_write : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (ex_alusel_o == `RES_NOP) |-> !ex_wreg_o
   );

endmodule

`default_nettype wire

//--- id_top.sv
`timescale 1ns/1ps
`default_nettype none

module id_top import mips_isa_pkg::*, id_ctrl_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_n_i,
   input  inst_t     inst_i,
   input  word_t     reg1_data_i,
   input  word_t     reg2_data_i,
   input  logic      ex_wreg_i,
   input  reg_addr_t ex_wd_i,
   input  word_t     ex_wdata_i,
   input  logic      mem_wreg_i,
   input  reg_addr_t mem_wd_i,
   input  word_t     mem_wdata_i,
   output logic      reg1_read_o,
   output logic      reg2_read_o,
   output reg_addr_t reg1_addr_o,
   output reg_addr_t reg2_addr_o,
   output aluop_t    ex_aluop_o,
   output alusel_t   ex_alusel_o,
   output word_t     ex_reg1_o,
   output word_t     ex_reg2_o,
   output reg_addr_t ex_wd_o,
   output logic      ex_wreg_o,
   output logic      ex_invalid_o
);

   word_t opnd1;
   word_t opnd2;

   id_dec_if dec_if ();

   inst_decoder i_dec (
      .inst_i (inst_i),
      .dec    (dec_if.dec)
   );

   // register file read request, same cycle as decode
   assign reg1_read_o = dec_if.reg1_read;
   assign reg2_read_o = dec_if.reg2_read;
   assign reg1_addr_o = dec_if.reg1_addr;
   assign reg2_addr_o = dec_if.reg2_addr;

   operand_forward i_opnd1 (
      .opnd        (dec_if.opnd),
      .sel_i       (1'b0),
      .rf_data_i   (reg1_data_i),
      .ex_wreg_i   (ex_wreg_i),
      .ex_wd_i     (ex_wd_i),
      .ex_wdata_i  (ex_wdata_i),
      .mem_wreg_i  (mem_wreg_i),
      .mem_wd_i    (mem_wd_i),
      .mem_wdata_i (mem_wdata_i),
      .operand_o   (opnd1)
   );

   operand_forward i_opnd2 (
      .opnd        (dec_if.opnd),
      .sel_i       (1'b1),
      .rf_data_i   (reg2_data_i),
      .ex_wreg_i   (ex_wreg_i),
      .ex_wd_i     (ex_wd_i),
      .ex_wdata_i  (ex_wdata_i),
      .mem_wreg_i  (mem_wreg_i),
      .mem_wd_i    (mem_wd_i),
      .mem_wdata_i (mem_wdata_i),
      .operand_o   (opnd2)
   );

   id_ex_reg i_pipe (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .pipe         (dec_if.pipe),
      .reg1_i       (opnd1),
      .reg2_i       (opnd2),
      .ex_aluop_o   (ex_aluop_o),
      .ex_alusel_o  (ex_alusel_o),
      .ex_reg1_o    (ex_reg1_o),
      .ex_reg2_o    (ex_reg2_o),
      .ex_wd_o      (ex_wd_o),
      .ex_wreg_o    (ex_wreg_o),
      .ex_invalid_o (ex_invalid_o)
   );

endmodule

`default_nettype wire

//--- tb_id_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_macros.svh"

module tb_id_top import mips_isa_pkg::*, id_ctrl_pkg::*; ();

   logic        clk_i;
   logic        rst_n_i;
   inst_t       inst_i;
   word_t       reg1_data_i;
   word_t       reg2_data_i;
   logic        ex_wreg_i;
   reg_addr_t   ex_wd_i;
   word_t       ex_wdata_i;
   logic        mem_wreg_i;
   reg_addr_t   mem_wd_i;
   word_t       mem_wdata_i;
   logic        reg1_read_o;
   logic        reg2_read_o;
   reg_addr_t   reg1_addr_o;
   reg_addr_t   reg2_addr_o;
   aluop_t      ex_aluop_o;
   alusel_t     ex_alusel_o;
   word_t       ex_reg1_o;
   word_t       ex_reg2_o;
   reg_addr_t   ex_wd_o;
   logic        ex_wreg_o;
   logic        ex_invalid_o;

   int          cycle_cnt;
   int          err_cnt;
   int          test_cnt;
   int          failed_tests;
   int          test_err0;
   int unsigned seed_draw;

   id_top i_dut (.*);

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

   // register file model whose contents depend on every address bit
   function automatic word_t rf_data(input reg_addr_t addr);
      return {addr, 3'b101, ~addr, 3'b010, addr, 1'b1, addr, addr};
   endfunction

   assign reg1_data_i = rf_data(reg1_addr_o);
   assign reg2_data_i = rf_data(reg2_addr_o);

   function automatic aluop_t rtype_aluop(input funct_t fn);
      case (fn)
         `FN_OR:            return `ALUOP_OR;
         `FN_AND:           return `ALUOP_AND;
         `FN_XOR:           return `ALUOP_XOR;
         `FN_NOR:           return `ALUOP_NOR;
         `FN_SLL, `FN_SLLV: return `ALUOP_SLL;
         `FN_SRL, `FN_SRLV: return `ALUOP_SRL;
         `FN_SRA, `FN_SRAV: return `ALUOP_SRA;
         `FN_ADD:           return `ALUOP_ADD;
         `FN_ADDU:          return `ALUOP_ADDU;
         `FN_SUB:           return `ALUOP_SUB;
         `FN_SUBU:          return `ALUOP_SUBU;
         `FN_SLT:           return `ALUOP_SLT;
         `FN_SLTU:          return `ALUOP_SLTU;
         default:           return `ALUOP_NOP;
      endcase
   endfunction

   function automatic alusel_t rtype_class(input funct_t fn);
      case (fn)
         `FN_OR, `FN_AND, `FN_XOR, `FN_NOR:
            return `RES_LOGIC;
         `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV:
            return `RES_SHIFT;
         `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU:
            return `RES_ARITH;
         default:
            return `RES_NOP;
      endcase
   endfunction

   function automatic aluop_t imm_aluop(input opcode_t op);
      case (op)
         `OP_ORI, `OP_LUI: return `ALUOP_OR;
         `OP_ANDI:         return `ALUOP_AND;
         `OP_XORI:         return `ALUOP_XOR;
         `OP_ADDI:         return `ALUOP_ADDI;
         `OP_ADDIU:        return `ALUOP_ADDIU;
         `OP_SLTI:         return `ALUOP_SLT;
         `OP_SLTIU:        return `ALUOP_SLTU;
         default:          return `ALUOP_NOP;
      endcase
   endfunction

   function automatic alusel_t imm_class(input opcode_t op);
      case (op)
         `OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI:          return `RES_LOGIC;
         `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU:      return `RES_ARITH;
         default:                                       return `RES_NOP;
      endcase
   endfunction

   function automatic word_t imm_ext(input opcode_t op, input imm16_t imm);
      if (op == `OP_LUI)
         return {imm, 16'h0000};
      if (op == `OP_ORI || op == `OP_ANDI || op == `OP_XORI)
         return {16'h0000, imm};
      return {{16{imm[15]}}, imm};
   endfunction

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp) else begin
         $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
         err_cnt++;
      end
   endtask

   // returns 1 ns after the next rising edge
   task automatic next_edge();
      int start;
      int polls;
      start = cycle_cnt;
      polls = 0;
      while (cycle_cnt == start) begin
         if (polls >= 400) begin
            $display("timeout: no rising clock edge seen within 200 ns");
            $display("TESTS FAILED");
            $finish;
         end
         #0.5;
         polls++;
      end
      #0.5;
   endtask

   task automatic issue(input inst_t inst, input logic r1_rd, input logic r2_rd);
      inst_i = inst;
      #1;
      check_val("reg1_read_o", reg1_read_o, r1_rd);
      check_val("reg2_read_o", reg2_read_o, r2_rd);
      check_val("reg1_addr_o", reg1_addr_o, inst[25:21]);   // always rs
      check_val("reg2_addr_o", reg2_addr_o, inst[20:16]);   // always rt
      next_edge();
   endtask

   task automatic check_ex(input aluop_t aluop, input alusel_t sel, input word_t r1,
                           input word_t r2, input reg_addr_t wd);
      check_val("ex_aluop_o", ex_aluop_o, aluop);
      check_val("ex_alusel_o", ex_alusel_o, sel);
      check_val("ex_reg1_o", ex_reg1_o, r1);
      check_val("ex_reg2_o", ex_reg2_o, r2);
      check_val("ex_wd_o", ex_wd_o, wd);
      check_val("ex_wreg_o", ex_wreg_o, 1'b1);
      check_val("ex_invalid_o", ex_invalid_o, 1'b0);
   endtask

   task automatic check_invalid();
      check_val("ex_invalid_o", ex_invalid_o, 1'b1);
      check_val("ex_wreg_o", ex_wreg_o, 1'b0);
      check_val("ex_aluop_o", ex_aluop_o, `ALUOP_NOP);
      check_val("ex_alusel_o", ex_alusel_o, `RES_NOP);
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      if (err_cnt == test_err0) begin
         $display("%s: ok", name);
      end else begin
         failed_tests++;
         $display("%s: %0d errors", name, err_cnt - test_err0);
      end
      test_err0 = err_cnt;
   endtask

   task automatic test_reset();
      rst_n_i = 1'b0;
      inst_i  = {`OP_SPECIAL, 5'd3, 5'd4, 5'd5, 5'd0, `FN_ADD};   // valid ADD
      next_edge();
      next_edge();
      check_val("ex_aluop_o", ex_aluop_o, `ALUOP_NOP);
      check_val("ex_alusel_o", ex_alusel_o, `RES_NOP);
      check_val("ex_reg1_o", ex_reg1_o, 32'h0);
      check_val("ex_reg2_o", ex_reg2_o, 32'h0);
      check_val("ex_wd_o", ex_wd_o, `NOP_REG_ADDR);
      check_val("ex_wreg_o", ex_wreg_o, 1'b0);
      check_val("ex_invalid_o", ex_invalid_o, 1'b0);
      rst_n_i = 1'b1;
      end_test("reset");
   endtask

   task automatic test_rtype();
      funct_t    fns [0:9];
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t rd;
      fns = '{`FN_OR, `FN_AND, `FN_XOR, `FN_NOR, `FN_ADD,
              `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU};
      foreach (fns[i]) begin
         rs = $urandom_range(31);
         rt = $urandom_range(31);
         rd = $urandom_range(31);
         issue({`OP_SPECIAL, rs, rt, rd, 5'd0, fns[i]}, 1'b1, 1'b1);
         check_ex(rtype_aluop(fns[i]), rtype_class(fns[i]), rf_data(rs), rf_data(rt), rd);
      end
      end_test("register-form");
   endtask

   task automatic test_imm();
      opcode_t   ops [0:7];
      imm16_t    imm;
      reg_addr_t rs;
      reg_addr_t rt;
      ops = '{`OP_ORI, `OP_ANDI, `OP_XORI, `OP_LUI,
              `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU};
      foreach (ops[i]) begin
         for (int s = 0; s < 2; s++) begin
            rs  = $urandom_range(31);
            rt  = $urandom_range(31);
            imm = $urandom_range(16'h7fff);
            if (s == 1)
               imm[15] = 1'b1;   // negative for sign-extending forms
            issue({ops[i], rs, rt, imm}, 1'b1, 1'b0);
            check_ex(imm_aluop(ops[i]), imm_class(ops[i]), rf_data(rs),
                     imm_ext(ops[i], imm), rt);
         end
      end
      end_test("immediate");
   endtask

   task automatic test_shift();
      funct_t    fns [0:2];
      shamt_t    sa;
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t rd;
      fns = '{`FN_SLL, `FN_SRL, `FN_SRA};
      foreach (fns[i]) begin
         rt = $urandom_range(31);
         rd = $urandom_range(31);
         sa = $urandom_range(31, 1);
         issue({`OP_SPECIAL, 5'd0, rt, rd, sa, fns[i]}, 1'b0, 1'b1);
         check_ex(rtype_aluop(fns[i]), `RES_SHIFT, {27'd0, sa}, rf_data(rt), rd);
      end
      fns = '{`FN_SLLV, `FN_SRLV, `FN_SRAV};
      foreach (fns[i]) begin
         rs = $urandom_range(31);
         rt = $urandom_range(31);
         rd = $urandom_range(31);
         issue({`OP_SPECIAL, rs, rt, rd, 5'd0, fns[i]}, 1'b1, 1'b1);
         check_ex(rtype_aluop(fns[i]), `RES_SHIFT, rf_data(rs), rf_data(rt), rd);
      end
      issue({`OP_SPECIAL, rs, rt, rd, 5'd7, `FN_ADD}, 1'b0, 1'b0);   // shamt must be 0
      check_invalid();
      end_test("shift");
   endtask

   task automatic test_forward();
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t tgt;
      word_t     fwd;
      word_t     exp1;
      word_t     exp2;
      for (int opn = 0; opn < 2; opn++) begin
         // EX only, MEM only, both, then enables low
         for (int c = 0; c < 4; c++) begin
            rs          = $urandom_range(31);
            rt          = rs ^ 5'($urandom_range(31, 1));
            tgt         = (opn == 0) ? rs : rt;
            ex_wdata_i  = $urandom;
            mem_wdata_i = $urandom;
            ex_wd_i     = tgt;
            mem_wd_i    = tgt;
            ex_wreg_i   = (c == 0 || c == 2);
            mem_wreg_i  = (c == 1 || c == 2);
            if (c == 0 || c == 2)
               fwd = ex_wdata_i;
            else if (c == 1)
               fwd = mem_wdata_i;
            else
               fwd = rf_data(tgt);
            exp1 = (opn == 0) ? fwd : rf_data(rs);
            exp2 = (opn == 1) ? fwd : rf_data(rt);
            issue({`OP_SPECIAL, rs, rt, 5'd9, 5'd0, `FN_ADDU}, 1'b1, 1'b1);
            check_ex(`ALUOP_ADDU, `RES_ARITH, exp1, exp2, 5'd9);
         end
      end
      ex_wreg_i  = 1'b0;
      mem_wreg_i = 1'b0;
      end_test("forwarding");
   endtask

   task automatic test_invalid();
      opcode_t op;
      funct_t  fn;
      for (int i = 0; i < 8; i++) begin
         op = $urandom_range(63);
         while (op == `OP_SPECIAL || imm_class(op) != `RES_NOP)
            op = $urandom_range(63);
         issue({op, 26'($urandom)}, 1'b0, 1'b0);
         check_invalid();
         fn = $urandom_range(63);
         while (rtype_class(fn) != `RES_NOP)
            fn = $urandom_range(63);
         issue({`OP_SPECIAL, 15'($urandom), 5'd0, fn}, 1'b0, 1'b0);
         check_invalid();
      end
      end_test("invalid");
   endtask

   initial begin
      seed_draw    = $urandom(33244);
      clk_i        = 1'b0;
      rst_n_i      = 1'b0;
      inst_i       = '0;
      ex_wreg_i    = 1'b0;
      ex_wd_i      = '0;
      ex_wdata_i   = '0;
      mem_wreg_i   = 1'b0;
      mem_wd_i     = '0;
      mem_wdata_i  = '0;
      cycle_cnt    = 0;
      err_cnt      = 0;
      test_cnt     = 0;
      failed_tests = 0;
      test_err0    = 0;
      test_reset();
      test_rtype();
      test_imm();
      test_shift();
      test_forward();
      test_invalid();
      $display("%0d tests run, %0d failed, %0d check errors",
               test_cnt, failed_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- id_top.f
+incdir+.
mips_isa_pkg.sv
id_ctrl_pkg.sv
id_dec_if.sv
inst_decoder.sv
operand_forward.sv
id_ex_reg.sv
id_top.sv
tb_id_top.sv
